//--- source/maze_render_pkg.sv
`default_nettype none

package maze_render_pkg;

    typedef logic [9:0] coord_t;
    typedef logic [3:0] channel_t;

    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
    } rgb_t;

    typedef enum logic [1:0] {
        dir_right = 2'd0,
        dir_left  = 2'd1,
        dir_up    = 2'd2,
        dir_down  = 2'd3
    } dir_e;

    typedef enum logic [2:0] {
        state_idle    = 3'd0,
        state_playing = 3'd1,
        state_win     = 3'd2,
        state_lose    = 3'd3
    } game_state_e;

    // top-left corner of a sprite box and the way it faces
    typedef struct packed {
        coord_t x;
        coord_t y;
        dir_e   dir;
    } sprite_pos_t;

    typedef struct packed {
        coord_t      x;
        coord_t      y;
        logic        active;
        game_state_e state;
    } pixel_req_t;

    typedef struct packed {
        logic wall;
        rgb_t colour;
    } maze_px_t;

    typedef struct packed {
        logic hit;
        rgb_t colour;
    } sprite_px_t;

    // tiles and sprites share one edge length, the masks below are drawn for 8
    localparam int TILE_SIZE = 8;

    typedef logic [$clog2(TILE_SIZE)-1:0]   offset_t;
    typedef logic [2*$clog2(TILE_SIZE)-1:0] mask_idx_t;
    typedef logic [TILE_SIZE*TILE_SIZE-1:0] sprite_mask_t;

    // one byte per row with row 7 leftmost in the literal
    // bit 0 of each byte is the leftmost column on screen
    localparam sprite_mask_t PLAYER_MASK_F0 = 64'h3C7E_3F0F_0F3F_7E3C;
    localparam sprite_mask_t PLAYER_MASK_F1 = 64'h3C7E_FFFF_FFFF_7E3C;

    // the skirt in the bottom row alternates between the two frames
    localparam sprite_mask_t GHOST_MASK_F0 = 64'h6DFF_FFFF_FFFF_7E3C;
    localparam sprite_mask_t GHOST_MASK_F1 = 64'hB6FF_FFFF_FFFF_7E3C;

    localparam sprite_mask_t SCLERA_MASK = 64'h0000_0066_6666_0000;

    // indexed by dir_e, every pupil sits inside the sclera
    localparam sprite_mask_t PUPIL_MASK [4] = '{
        64'h0000_0044_4400_0000,
        64'h0000_0022_2200_0000,
        64'h0000_0000_0066_0000,
        64'h0000_0066_0000_0000
    };

    localparam sprite_mask_t DOT_MASK     = 64'h0000_0018_1800_0000;
    localparam sprite_mask_t BIG_DOT_MASK = 64'h0000_3C3C_3C3C_0000;

    localparam rgb_t WALL_COLOUR       = '{r: 4'h2, g: 4'h2, b: 4'hf};
    localparam rgb_t BACKGROUND_COLOUR = '{r: 4'h0, g: 4'h0, b: 4'h0};
    localparam rgb_t DOT_COLOUR        = '{r: 4'hf, g: 4'hf, b: 4'hf};
    localparam rgb_t PLAYER_COLOUR     = '{r: 4'hf, g: 4'hf, b: 4'h0};

    localparam rgb_t GHOST_COLOURS [4] = '{
        '{r: 4'hf, g: 4'h0, b: 4'h0},
        '{r: 4'hf, g: 4'hb, b: 4'hd},
        '{r: 4'h0, g: 4'hf, b: 4'hf},
        '{r: 4'hf, g: 4'ha, b: 4'h2}
    };

    localparam rgb_t SCLERA_COLOUR = '{r: 4'hf, g: 4'hf, b: 4'hf};
    localparam rgb_t PUPIL_COLOUR  = '{r: 4'h1, g: 4'h1, b: 4'h8};

    // shown for any game state that has no picture of its own
    localparam rgb_t DEBUG_COLOUR = '{r: 4'h7, g: 4'h4, b: 4'hf};

endpackage

`default_nettype wire

//--- source/animation_timer.sv
`default_nettype none

module animation_timer #(
    parameter int PLAYER_FRAME_CYCLES = 16,
    parameter int GHOST_FRAME_CYCLES  = 24
) (
    input  logic clk,
    input  logic rst_n,
    output logic player_frame,
    output logic ghost_frame
);

    localparam int MAX_CYCLES = (PLAYER_FRAME_CYCLES > GHOST_FRAME_CYCLES) ?
                                PLAYER_FRAME_CYCLES : GHOST_FRAME_CYCLES;
    localparam int CNT_W = $clog2(MAX_CYCLES + 1);
    localparam int PERIOD [2] = '{PLAYER_FRAME_CYCLES, GHOST_FRAME_CYCLES};

    logic [1:0] frame;

    // entry 0 paces the player, entry 1 the ghosts
    for (genvar i = 0; i < 2; i++) begin : g_frame
        logic [CNT_W-1:0] count;
        logic             toggle;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                count  <= '0;
                toggle <= 1'b0;
            end else if (count == CNT_W'(PERIOD[i] - 1)) begin
                count  <= '0;
                toggle <= ~toggle;
            end else begin
                count <= count + 1'b1;
            end
        end

        assign frame[i] = toggle;
    end

    assign player_frame = frame[0];
    assign ghost_frame  = frame[1];

endmodule

`default_nettype wire

//--- source/maze_layer.sv
`default_nettype none

module maze_layer #(
    parameter int TILE_COLS = 8,
    parameter int TILE_ROWS = 6
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  maze_render_pkg::pixel_req_t       pixel,
    input  logic [TILE_COLS*TILE_ROWS-1:0]    walls,
    input  logic [TILE_COLS*TILE_ROWS-1:0]    dots,
    input  logic [TILE_COLS*TILE_ROWS-1:0]    big_dots,
    output maze_render_pkg::maze_px_t         maze
);

    import maze_render_pkg::*;

    localparam int NUM_TILES = TILE_COLS * TILE_ROWS;
    localparam int IDX_W     = (NUM_TILES > 1) ? $clog2(NUM_TILES) : 1;

    coord_t           tile_col;
    coord_t           tile_row;
    offset_t          off_x;
    offset_t          off_y;
    mask_idx_t        mask_idx;
    logic             in_maze;
    logic [IDX_W-1:0] tile_idx;
    maze_px_t         next;
    logic             wall_q;
    rgb_t             colour_q;

    assign tile_col = pixel.x >> $bits(offset_t);
    assign tile_row = pixel.y >> $bits(offset_t);
    assign off_x    = offset_t'(pixel.x);
    assign off_y    = offset_t'(pixel.y);
    assign mask_idx = {off_y, off_x};
    assign in_maze  = (tile_col < coord_t'(TILE_COLS)) && (tile_row < coord_t'(TILE_ROWS));
    assign tile_idx = IDX_W'(tile_col + tile_row * coord_t'(TILE_COLS));

    // a big dot hides a plain dot on the same tile
    always_comb begin
        next = '{wall: 1'b0, colour: BACKGROUND_COLOUR};
        if (in_maze) begin
            if (walls[tile_idx]) begin
                next = '{wall: 1'b1, colour: WALL_COLOUR};
            end else if (big_dots[tile_idx]) begin
                if (BIG_DOT_MASK[mask_idx]) begin
                    next.colour = DOT_COLOUR;
                end
            end else if (dots[tile_idx] && DOT_MASK[mask_idx]) begin
                next.colour = DOT_COLOUR;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wall_q <= 1'b0;
        end else begin
            wall_q <= next.wall;
        end
    end

    always_ff @(posedge clk) begin
        colour_q <= next.colour;
    end

    assign maze = '{wall: wall_q, colour: colour_q};

endmodule

`default_nettype wire

//--- source/sprite_layer.sv
`default_nettype none

module sprite_layer #(
    parameter int NUM_GHOSTS = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  maze_render_pkg::pixel_req_t  pixel,
    input  maze_render_pkg::sprite_pos_t player,
    input  maze_render_pkg::sprite_pos_t ghosts [NUM_GHOSTS],
    input  logic                         player_frame,
    input  logic                         ghost_frame,
    output maze_render_pkg::sprite_px_t  sprite
);

    import maze_render_pkg::*;

    typedef logic [$bits(coord_t):0] coord_ext_t;

    localparam offset_t EDGE = offset_t'(TILE_SIZE - 1);

    offset_t      px_col;
    offset_t      px_row;
    offset_t      rot_col;
    offset_t      rot_row;
    sprite_mask_t player_mask;
    logic         found;
    sprite_px_t   next;
    logic         hit_q;
    rgb_t         colour_q;

    // one extra bit keeps a box at the right or bottom edge from wrapping to zero
    function automatic logic in_box(coord_t px, coord_t py, sprite_pos_t pos);
        coord_ext_t x_end;
        coord_ext_t y_end;
        x_end = {1'b0, pos.x} + coord_ext_t'(TILE_SIZE);
        y_end = {1'b0, pos.y} + coord_ext_t'(TILE_SIZE);
        return (px >= pos.x) && ({1'b0, px} < x_end) &&
               (py >= pos.y) && ({1'b0, py} < y_end);
    endfunction

    function automatic offset_t rel_offset(coord_t p, coord_t origin);
        return offset_t'(p - origin);
    endfunction

    // pupils draw over the sclera, the sclera over the body
    function automatic sprite_px_t ghost_px(coord_t px, coord_t py, sprite_pos_t pos,
                                            logic frame, rgb_t body);
        mask_idx_t    idx;
        sprite_mask_t body_mask;
        sprite_mask_t pupil_mask;
        sprite_px_t   result;
        idx        = {rel_offset(py, pos.y), rel_offset(px, pos.x)};
        body_mask  = frame ? GHOST_MASK_F1 : GHOST_MASK_F0;
        pupil_mask = PUPIL_MASK[pos.dir];
        result.hit = body_mask[idx] | SCLERA_MASK[idx] | pupil_mask[idx];
        if (pupil_mask[idx]) begin
            result.colour = PUPIL_COLOUR;
        end else if (SCLERA_MASK[idx]) begin
            result.colour = SCLERA_COLOUR;
        end else begin
            result.colour = body;
        end
        return result;
    endfunction

    assign px_col = rel_offset(pixel.x, player.x);
    assign px_row = rel_offset(pixel.y, player.y);

    // the masks face right, other headings turn the lookup
    always_comb begin
        case (player.dir)
            dir_left: begin
                rot_col = EDGE - px_col;
                rot_row = px_row;
            end
            dir_up: begin
                rot_col = EDGE - px_row;
                rot_row = px_col;
            end
            dir_down: begin
                rot_col = px_row;
                rot_row = EDGE - px_col;
            end
            default: begin
                rot_col = px_col;
                rot_row = px_row;
            end
        endcase
    end

    assign player_mask = player_frame ? PLAYER_MASK_F1 : PLAYER_MASK_F0;

    // the first box that holds the pixel decides, even where its mask is clear
    always_comb begin
        found = 1'b0;
        next  = '{hit: 1'b0, colour: BACKGROUND_COLOUR};
        if (in_box(pixel.x, pixel.y, player)) begin
            found = 1'b1;
            next  = '{hit: player_mask[{rot_row, rot_col}], colour: PLAYER_COLOUR};
        end
        for (int i = 0; i < NUM_GHOSTS; i++) begin
            if (!found && in_box(pixel.x, pixel.y, ghosts[i])) begin
                found = 1'b1;
                next  = ghost_px(pixel.x, pixel.y, ghosts[i], ghost_frame, GHOST_COLOURS[i]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= next.hit;
        end
    end

    always_ff @(posedge clk) begin
        colour_q <= next.colour;
    end

    assign sprite = '{hit: hit_q, colour: colour_q};

endmodule

`default_nettype wire

//--- source/pixel_compositor.sv
`default_nettype none

module pixel_compositor (
    input  logic                        clk,
    input  logic                        rst_n,
    input  maze_render_pkg::pixel_req_t pixel,
    input  maze_render_pkg::maze_px_t   maze,
    input  maze_render_pkg::sprite_px_t sprite,
    output maze_render_pkg::rgb_t       rgb
);

    import maze_render_pkg::*;

    localparam rgb_t BLACK = '{r: 4'h0, g: 4'h0, b: 4'h0};

    logic        active_q;
    game_state_e state_q;
    rgb_t        next;

    // the layers answer one cycle late, so the control fields wait as well
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            state_q  <= state_idle;
        end else begin
            active_q <= pixel.active;
            state_q  <= pixel.state;
        end
    end

    // walls sit in front of sprites, sprites in front of dots and floor
    always_comb begin
        if (!active_q) begin
            next = BLACK;
        end else if (state_q != state_playing && state_q != state_win) begin
            next = DEBUG_COLOUR;
        end else if (sprite.hit && !maze.wall) begin
            next = sprite.colour;
        end else begin
            next = maze.colour;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb <= BLACK;
        end else begin
            rgb <= next;
        end
    end

endmodule

`default_nettype wire

//--- source/maze_renderer.sv
`default_nettype none

module maze_renderer #(
    parameter int TILE_COLS           = 8,
    parameter int TILE_ROWS           = 6,
    parameter int NUM_GHOSTS          = 4,
    parameter int PLAYER_FRAME_CYCLES = 16,
    parameter int GHOST_FRAME_CYCLES  = 24
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  maze_render_pkg::pixel_req_t    pixel,
    input  logic [TILE_COLS*TILE_ROWS-1:0] walls,
    input  logic [TILE_COLS*TILE_ROWS-1:0] dots,
    input  logic [TILE_COLS*TILE_ROWS-1:0] big_dots,
    input  maze_render_pkg::sprite_pos_t   player,
    input  maze_render_pkg::sprite_pos_t   ghosts [NUM_GHOSTS],
    output maze_render_pkg::rgb_t          rgb
);

    import maze_render_pkg::*;

    logic       player_frame;
    logic       ghost_frame;
    maze_px_t   maze;
    sprite_px_t sprite;

    animation_timer #(
        .PLAYER_FRAME_CYCLES(PLAYER_FRAME_CYCLES),
        .GHOST_FRAME_CYCLES (GHOST_FRAME_CYCLES)
    ) i_animation_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .player_frame(player_frame),
        .ghost_frame (ghost_frame)
    );

    maze_layer #(
        .TILE_COLS(TILE_COLS),
        .TILE_ROWS(TILE_ROWS)
    ) i_maze_layer (
        .clk     (clk),
        .rst_n   (rst_n),
        .pixel   (pixel),
        .walls   (walls),
        .dots    (dots),
        .big_dots(big_dots),
        .maze    (maze)
    );

    sprite_layer #(
        .NUM_GHOSTS(NUM_GHOSTS)
    ) i_sprite_layer (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel       (pixel),
        .player      (player),
        .ghosts      (ghosts),
        .player_frame(player_frame),
        .ghost_frame (ghost_frame),
        .sprite      (sprite)
    );

    pixel_compositor i_pixel_compositor (
        .clk   (clk),
        .rst_n (rst_n),
        .pixel (pixel),
        .maze  (maze),
        .sprite(sprite),
        .rgb   (rgb)
    );

endmodule

`default_nettype wire

//--- bench/maze_renderer_properties.sv
`default_nettype none

module maze_renderer_properties (
    input logic                        clk,
    input logic                        rst_n,
    input maze_render_pkg::pixel_req_t pixel,
    input maze_render_pkg::rgb_t       rgb
);

    import maze_render_pkg::*;

    int failures = 0;

    // results leave the pipeline two edges after the request is sampled
    blank_when_inactive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$past(pixel.active, 2) |-> rgb == '0
    ) else begin
        failures++;
        $error("rgb not black two cycles after an inactive request");
    end

    debug_outside_play: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(pixel.active, 2) &&
        ($past(pixel.state, 2) == state_idle || $past(pixel.state, 2) == state_lose)
        |-> rgb == DEBUG_COLOUR
    ) else begin
        failures++;
        $error("rgb not the debug colour two cycles after an idle or lose request");
    end

    black_in_reset: assert property (
        @(posedge clk) !rst_n |-> rgb == '0
    ) else begin
        failures++;
        $error("rgb not black while reset is asserted");
    end

endmodule

bind maze_renderer maze_renderer_properties i_properties (
    .clk  (clk),
    .rst_n(rst_n),
    .pixel(pixel),
    .rgb  (rgb)
);

`default_nettype wire

//--- bench/maze_renderer_tb.sv
`default_nettype none

module maze_renderer_tb;

    import maze_render_pkg::*;

    localparam int TILE_COLS  = 8;
    localparam int TILE_ROWS  = 6;
    localparam int TILE_BITS  = TILE_COLS * TILE_ROWS;
    localparam int NUM_GHOSTS = 4;
    localparam int MAX_TRIES  = 4;

    // far outside the maze and every scanned area
    localparam sprite_pos_t PARKED = '{x: 10'd1000, y: 10'd1000, dir: dir_right};

    // one expected colour per frame pair, indexed by {player_frame, ghost_frame}
    typedef rgb_t [3:0] rgb_set_t;

    logic                 clk;
    logic                 rst_n;
    pixel_req_t           pixel;
    logic [TILE_BITS-1:0] walls;
    logic [TILE_BITS-1:0] dots;
    logic [TILE_BITS-1:0] big_dots;
    sprite_pos_t          player;
    sprite_pos_t          ghosts [NUM_GHOSTS];
    rgb_t                 rgb;

    logic [31:0] rng_state;
    rgb_set_t    pending [$];
    logic [3:0]  last_match;
    logic [1:0]  frame_fit;
    int          checks;
    int          errors;
    int          test_base;

    maze_renderer i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .pixel   (pixel),
        .walls   (walls),
        .dots    (dots),
        .big_dots(big_dots),
        .player  (player),
        .ghosts  (ghosts),
        .rgb     (rgb)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic pixel_req_t request(input int x, input int y, input game_state_e st);
        return '{x: coord_t'(x), y: coord_t'(y), active: 1'b1, state: st};
    endfunction

    // expected colour from the layer rules for one choice of animation frames
    function automatic rgb_t model_colour(input pixel_req_t req, input logic pf, input logic gf);
        int           tile;
        int           dx;
        int           dy;
        int           bit_idx;
        rgb_t         under;
        sprite_mask_t body;
        if (!req.active) begin
            return '0;
        end
        if (req.state != state_playing && req.state != state_win) begin
            return DEBUG_COLOUR;
        end
        under   = BACKGROUND_COLOUR;
        bit_idx = int'(req.x) % TILE_SIZE + (int'(req.y) % TILE_SIZE) * TILE_SIZE;
        if (int'(req.x) / TILE_SIZE < TILE_COLS && int'(req.y) / TILE_SIZE < TILE_ROWS) begin
            tile = int'(req.x) / TILE_SIZE + (int'(req.y) / TILE_SIZE) * TILE_COLS;
            if (walls[tile]) begin
                return WALL_COLOUR;
            end
            if (big_dots[tile] ? BIG_DOT_MASK[bit_idx] : (dots[tile] && DOT_MASK[bit_idx])) begin
                under = DOT_COLOUR;
            end
        end
        dx = int'(req.x) - int'(player.x);
        dy = int'(req.y) - int'(player.y);
        if (dx >= 0 && dx < TILE_SIZE && dy >= 0 && dy < TILE_SIZE) begin
            case (player.dir)
                dir_left: bit_idx = (TILE_SIZE - 1 - dx) + dy * TILE_SIZE;
                dir_up:   bit_idx = (TILE_SIZE - 1 - dy) + dx * TILE_SIZE;
                dir_down: bit_idx = dy + (TILE_SIZE - 1 - dx) * TILE_SIZE;
                default:  bit_idx = dx + dy * TILE_SIZE;
            endcase
            body = pf ? PLAYER_MASK_F1 : PLAYER_MASK_F0;
            return body[bit_idx] ? PLAYER_COLOUR : under;
        end
        for (int g = 0; g < NUM_GHOSTS; g++) begin
            dx = int'(req.x) - int'(ghosts[g].x);
            dy = int'(req.y) - int'(ghosts[g].y);
            if (dx >= 0 && dx < TILE_SIZE && dy >= 0 && dy < TILE_SIZE) begin
                bit_idx = dx + dy * TILE_SIZE;
                body    = gf ? GHOST_MASK_F1 : GHOST_MASK_F0;
                if (PUPIL_MASK[ghosts[g].dir][bit_idx]) begin
                    return PUPIL_COLOUR;
                end
                if (SCLERA_MASK[bit_idx]) begin
                    return SCLERA_COLOUR;
                end
                return body[bit_idx] ? GHOST_COLOURS[g] : under;
            end
        end
        return under;
    endfunction

    task automatic check_front();
        rgb_set_t   expected;
        logic [3:0] match;
        expected = pending.pop_front();
        for (int f = 0; f < 4; f++) begin
            match[f] = (rgb == expected[f]);
        end
        checks++;
        last_match = match;
        frame_fit  = frame_fit & {match[3] | match[2], match[1] | match[0]};
        assert (match != 4'b0000) else begin
            errors++;
            $display("[FAIL] %0t rgb expected %h got %h", $time, expected[0], rgb);
        end
    endtask

    // the answer for a request is on rgb two falling edges after it was driven
    task automatic send(input pixel_req_t req);
        rgb_set_t expected;
        @(negedge clk);
        if (pending.size() == 2) begin
            check_front();
        end
        for (int f = 0; f < 4; f++) begin
            expected[f] = model_colour(req, f[1], f[0]);
        end
        pending.push_back(expected);
        pixel = req;
    endtask

    // empties the pipeline so the maps and sprites may change afterwards
    task automatic flush();
        repeat (2) begin
            send('{x: '0, y: '0, active: 1'b0, state: state_idle});
        end
    endtask

    task automatic scan_box(input int x0, input int y0, input int w, input int h);
        for (int y = y0; y < y0 + h; y++) begin
            for (int x = x0; x < x0 + w; x++) begin
                send(request(x, y, state_playing));
            end
        end
    endtask

    // a row is repeated while an animation toggle falls inside it
    task automatic scan_player_row(input int row);
        int tries;
        tries = 0;
        do begin
            frame_fit = 2'b11;
            scan_box(int'(player.x), int'(player.y) + row, TILE_SIZE, 1);
            flush();
            tries++;
        end while (frame_fit == 2'b00 && tries < MAX_TRIES);
        assert (frame_fit != 2'b00) else begin
            errors++;
            $display("player row %0d never matched a single animation frame", row);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    initial begin
        #500000;
        $display("simulation timed out before all tests finished");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        pixel_req_t req;
        int         probe;
        logic [1:0] seen;
        clk       = 1'b0;
        rst_n     = 1'b0;
        pixel     = '{x: '0, y: '0, active: 1'b0, state: state_idle};
        walls     = '0;
        dots      = '0;
        big_dots  = '0;
        player    = PARKED;
        ghosts    = '{default: PARKED};
        rng_state = 32'h5273_1004;
        checks    = 0;
        errors    = 0;
        test_base = 0;
        frame_fit = 2'b11;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int n = 0; n < 40; n++) begin
            req = request(int'(next_random() % 72), int'(next_random() % 56),
                          game_state_e'(3'(next_random() % 4)));
            req.active = (next_random() % 3) != 0;
            send(req);
        end
        report_test("blanking");

        for (int map = 0; map < 2; map++) begin
            flush();
            walls    = TILE_BITS'({next_random(), next_random()} & {next_random(), next_random()});
            dots     = TILE_BITS'({next_random(), next_random()});
            big_dots = TILE_BITS'({next_random(), next_random()} & {next_random(), next_random()});
            for (int n = 0; n < 400; n++) begin
                send(request(int'(next_random() % 72), int'(next_random() % 56),
                             (n % 2 == 0) ? state_playing : state_win));
            end
        end
        report_test("maze_tiles");

        // player overlaps ghost 0, and ghost 0 reaches into the one wall tile
        flush();
        walls    = '0;
        dots     = '1;
        big_dots = '0;
        walls[3 + 3 * TILE_COLS] = 1'b1;
        player    = '{x: 10'd14, y: 10'd22, dir: dir_right};
        ghosts[0] = '{x: 10'd20, y: 10'd26, dir: dir_left};
        scan_box(12, 20, 20, 16);
        report_test("priority");

        flush();
        walls  = '0;
        dots   = '0;
        ghosts = '{default: PARKED};
        for (int d = 0; d < 4; d++) begin
            flush();
            player = '{x: 10'd30, y: 10'd20, dir: dir_e'(d)};
            for (int row = 0; row < TILE_SIZE; row++) begin
                scan_player_row(row);
            end
        end
        report_test("player_rotation");

        flush();
        player = PARKED;
        for (int g = 0; g < NUM_GHOSTS; g++) begin
            for (int d = 0; d < 4; d++) begin
                flush();
                ghosts    = '{default: PARKED};
                ghosts[g] = '{x: 10'd40, y: 10'd16, dir: dir_e'(d)};
                scan_box(40, 16, TILE_SIZE, TILE_SIZE);
            end
        end
        report_test("ghost_eyes");

        flush();
        ghosts = '{default: PARKED};
        player = '{x: 10'd30, y: 10'd20, dir: dir_right};
        probe  = 0;
        for (int i = TILE_SIZE * TILE_SIZE - 1; i >= 0; i--) begin
            if (PLAYER_MASK_F0[i] != PLAYER_MASK_F1[i]) begin
                probe = i;
            end
        end
        seen = 2'b00;
        for (int n = 0; n < 100 && seen != 2'b11; n++) begin
            send(request(30 + probe % TILE_SIZE, 20 + probe / TILE_SIZE, state_win));
            if (last_match[1:0] != 2'b00 && last_match[3:2] == 2'b00) begin
                seen[0] = 1'b1;
            end
            if (last_match[3:2] != 2'b00 && last_match[1:0] == 2'b00) begin
                seen[1] = 1'b1;
            end
        end
        assert (seen == 2'b11) else begin
            errors++;
            $display("player animation frame did not toggle within 100 cycles");
        end
        report_test("animation");

        flush();
        errors = errors + i_dut.i_properties.failures;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- maze_renderer.f
source/maze_render_pkg.sv
source/animation_timer.sv
source/maze_layer.sv
source/sprite_layer.sv
source/pixel_compositor.sv
source/maze_renderer.sv
bench/maze_renderer_properties.sv
bench/maze_renderer_tb.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module maze_renderer_tb \
    -f maze_renderer.f -o maze_renderer_sim &&
{ ./obj_dir/maze_renderer_sim +verilator+error+limit+1000 > sim.log 2>&1 || true; } &&
cat sim.log &&
! grep -q "Result: FAILED" sim.log &&
grep -q "Result: PASSED" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
